//--- list.f
+incdir+include
verilog/kgp_pkg.sv
verilog/kgp_prefix_tree.sv
verilog/carry_merge.sv
verilog/doubling_adder_top.sv
bench/tb_doubling_adder.sv

//--- run_sim.sh
#!/bin/sh
# Builds the doubling adder testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_doubling_adder \
  -f list.f \
  -o sim_tb_doubling_adder

# The run passes only if the pass message shows up in the simulator output.
output=$(./obj_dir/sim_tb_doubling_adder)
echo "$output"
echo "$output" | grep "TEST RESULT: PASS" > /dev/null

echo "Simulation finished successfully."

//--- bench/tb_doubling_adder.sv
// Testbench for the pipelined doubling adder with LFSR stimulus, reference model and checker.
`timescale 1ns/1ps
`include "adder_defs.svh"

module tb_doubling_adder;

  import kgp_pkg::*;

  localparam int NUM_RANDOM   = 2000;
  localparam int NUM_DIRECTED = 40;
  // One cycle per vector, doubled to cover gaps, reset and drain.
  localparam int MAX_CYCLES   = 2 * (NUM_RANDOM + NUM_DIRECTED);

  logic     clk = 1'b0;
  logic     arst_n;
  logic     in_valid;
  operand_t a;
  operand_t b;
  logic     cin;
  sum_t     sum;
  logic     out_valid;

  logic [31:0]              lfsr_state = 32'h1e8a;
  sum_t                     expected_q[$];
  sum_t                     exp_sum;
  logic [`PIPE_LATENCY-1:0] valid_hist = '0;
  logic                     result_seen = 1'b0;
  int                       sent_count = 0;
  int                       received_count = 0;
  int                       cycle_count = 0;

  doubling_adder_top dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .a         (a),
    .b         (b),
    .cin       (cin),
    .sum       (sum),
    .out_valid (out_valid)
  );

  always #5 clk = ~clk;

  // Taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
  endtask

  function automatic sum_t ref_sum(input operand_t x, input operand_t y, input logic c);
    return {1'b0, x} + {1'b0, y} + sum_t'(c);
  endfunction

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_sum(input sum_t got, input sum_t exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED at %0t ns: %s, sum %h, expected %h",
                               $time, what, got, exp));
    end
  endtask

  task automatic check_valid(input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED at %0t ns: out_valid is %b, expected %b",
                               $time, got, exp));
    end
  endtask

  task automatic drive_vector(input operand_t a_in, input operand_t b_in, input logic c_in);
    @(posedge clk);
    in_valid <= 1'b1;
    a        <= a_in;
    b        <= b_in;
    cin      <= c_in;
    expected_q.push_back(ref_sum(a_in, b_in, c_in));
    sent_count++;
  endtask

  // Idle cycles present inverted operands that must not reach sum.
  task automatic drive_idle();
    @(posedge clk);
    in_valid <= 1'b0;
    a        <= ~a;
    b        <= ~b;
    cin      <= ~cin;
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles.", MAX_CYCLES);
      $display("TEST RESULT: FAIL");
      $fatal(1);
    end
  end

  // Outputs are sampled on the falling edge, half a cycle after they settle.
  always @(negedge clk) begin
    check_valid(out_valid, valid_hist[`PIPE_LATENCY-1]);
    if (out_valid) begin
      if (expected_q.size() == 0) begin
        report_failure("out_valid was high while no result was outstanding.");
      end else begin
        exp_sum = expected_q.pop_front();
        check_sum(sum, exp_sum, $sformatf("result %0d", received_count));
        received_count++;
        result_seen = 1'b1;
      end
    end else if (!result_seen) begin
      check_sum(sum, '0, "sum before the first result");
    end else begin
      check_sum(sum, exp_sum, "sum held between results");
    end
    valid_hist = {valid_hist[`PIPE_LATENCY-2:0], in_valid & arst_n};
  end

  initial begin
    logic [63:0] ra;
    logic [63:0] rb;
    logic [63:0] rc;
    logic [63:0] gap;
    operand_t    ones;
    ones     = '1;
    arst_n   = 1'b0;
    in_valid = 1'b0;
    a        = '0;
    b        = '0;
    cin      = 1'b0;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    repeat (5) drive_idle();  // Still no input, sum must stay 0.

    // Carry ripple across the full width.
    drive_vector(ones, '0, 1'b1);
    drive_vector('0, ones, 1'b1);
    drive_vector(ones, ones, 1'b1);
    drive_vector(ones, ones, 1'b0);
    drive_vector('0, '0, 1'b0);
    drive_vector('0, '0, 1'b1);
    drive_vector(ones, 64'd1, 1'b0);
    drive_vector(64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, 1'b0);

    // The low half passes a carry into a random high half.
    for (int n = 0; n < NUM_DIRECTED - 8; n++) begin
      take_bits(32, ra);
      take_bits(32, rb);
      if (n % 2 == 0) begin
        drive_vector({ra[31:0], 32'hffff_ffff}, {rb[31:0], 32'h0}, 1'b1);
      end else begin
        drive_vector({ra[31:0], 32'h0}, {rb[31:0], 32'hffff_ffff}, 1'b1);
      end
    end

    for (int n = 0; n < NUM_RANDOM / 2; n++) begin
      take_bits(64, ra);
      take_bits(64, rb);
      take_bits(1, rc);
      drive_vector(ra, rb, rc[0]);
    end

    // Streaming with gaps, about one cycle in four idle.
    for (int n = 0; n < NUM_RANDOM / 2; n++) begin
      take_bits(2, gap);
      while (gap[1:0] == 2'b00) begin
        drive_idle();
        take_bits(2, gap);
      end
      take_bits(64, ra);
      take_bits(64, rb);
      take_bits(1, rc);
      drive_vector(ra, rb, rc[0]);
    end
    drive_idle();

    while (received_count < sent_count) begin
      @(negedge clk);
    end
    repeat (5) @(posedge clk);

    if (received_count == NUM_RANDOM + NUM_DIRECTED && expected_q.size() == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("Received %0d results, but %0d were sent.", received_count, sent_count);
      $display("TEST RESULT: FAIL");
      $fatal(1);
    end
  end

endmodule

//--- verilog/doubling_adder_top.sv
// Top level of the pipelined 64-bit doubling adder, two prefix trees and a carry merge.
`timescale 1ns/1ps
`include "adder_defs.svh"

module doubling_adder_top (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              in_valid,
  input  kgp_pkg::operand_t a,
  input  kgp_pkg::operand_t b,
  input  logic              cin,
  output kgp_pkg::sum_t     sum,
  output logic              out_valid
);

  import kgp_pkg::*;

  half_result_t lo_res;
  half_result_t hi_res;

  kgp_prefix_tree #(
    .WIDTH (`HALF_WIDTH)
  ) lo_tree (
    .clk    (clk),
    .arst_n (arst_n),
    .a      (a[`HALF_WIDTH-1:0]),
    .b      (b[`HALF_WIDTH-1:0]),
    .result (lo_res)
  );

  // Runs in parallel with the low tree and knows nothing of the low carries.
  kgp_prefix_tree #(
    .WIDTH (`HALF_WIDTH)
  ) hi_tree (
    .clk    (clk),
    .arst_n (arst_n),
    .a      (a[`ADD_WIDTH-1:`HALF_WIDTH]),
    .b      (b[`ADD_WIDTH-1:`HALF_WIDTH]),
    .result (hi_res)
  );

  carry_merge merge (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .cin       (cin),
    .lo        (lo_res),
    .hi        (hi_res),
    .sum       (sum),
    .out_valid (out_valid)
  );

endmodule

//--- verilog/carry_merge.sv
// Final doubling level across the two halves, carry resolution and sum register.
`timescale 1ns/1ps
`include "adder_defs.svh"

module carry_merge (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  in_valid,
  input  logic                  cin,
  input  kgp_pkg::half_result_t lo,
  input  kgp_pkg::half_result_t hi,
  output kgp_pkg::sum_t         sum,
  output logic                  out_valid
);

  import kgp_pkg::*;

  localparam int HW = `HALF_WIDTH;

  logic          valid_q;  // Travels alongside the tree registers.
  logic          cin_q;
  logic [HW-1:0] lo_carry;
  logic [HW-1:0] hi_carry;
  logic          lo_cout;
  logic          hi_cout;
  sum_t          sum_d;

  // First stage matches the registers inside both trees.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
      cin_q   <= 1'b0;
    end else begin
      valid_q <= in_valid;
      cin_q   <= cin;
    end
  end

  // Low half resolves straight against the carry in.
  always_comb begin
    lo_carry[0] = cin_q;
    for (int i = 1; i < HW; i++) begin
      lo_carry[i] = kgp_resolve(lo.grp[i-1], cin_q);
    end
    lo_cout = kgp_resolve(lo.grp[HW-1], cin_q);
  end

  // The sixth level. The high groups reach down through the whole low half.
  always_comb begin
    hi_carry[0] = lo_cout;
    for (int j = 1; j < HW; j++) begin
      hi_carry[j] = kgp_resolve(hi.grp[j-1], lo_cout);
    end
    hi_cout = kgp_resolve(hi.grp[HW-1], lo_cout);
  end

  assign sum_d = {hi_cout, hi.hsum ^ hi_carry, lo.hsum ^ lo_carry};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sum       <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= valid_q;
      if (valid_q) begin
        sum <= sum_d;  // Holds the last result between valid cycles.
      end
    end
  end

  // The strobe takes exactly two edges from in_valid to out_valid.
  a_valid_delay: assert property (
    @(posedge clk) disable iff (!arst_n)
    $past(arst_n) && $past(arst_n, 2) |-> out_valid == $past(in_valid, 2)
  ) else $error("out_valid does not follow in_valid by two edges.");

  // Both trees must deliver clean symbols whenever a result is formed.
  a_sym_known: assert property (
    @(posedge clk) disable iff (!arst_n)
    valid_q |-> !$isunknown({lo.grp, hi.grp})
  ) else $error("Unknown group symbol code on a valid cycle.");

endmodule

//--- verilog/kgp_prefix_tree.sv
// Registered Kogge-Stone prefix tree over one operand half, with half-sum bits.
`timescale 1ns/1ps
`include "adder_defs.svh"

module kgp_prefix_tree #(
  parameter int WIDTH = `HALF_WIDTH
) (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic [WIDTH-1:0]        a,
  input  logic [WIDTH-1:0]        b,
  output kgp_pkg::half_result_t   result
);

  import kgp_pkg::*;

  localparam int LEVELS = $clog2(WIDTH);

  // Level 0 holds the raw bit symbols, level LEVELS the group symbols.
  kgp_sym_u lvl [0:LEVELS][0:WIDTH-1];
  logic [WIDTH-1:0] hsum;

  assign hsum = a ^ b;

  for (genvar i = 0; i < WIDTH; i++) begin : g_encode
    assign lvl[0][i] = kgp_encode(a[i], b[i]);
  end

  // Level k joins each symbol with the one 2^k positions below it.
  for (genvar k = 0; k < LEVELS; k++) begin : g_level
    localparam int DIST = 1 << k;
    for (genvar i = 0; i < WIDTH; i++) begin : g_bit
      if (i < DIST) begin : g_pass
        assign lvl[k+1][i] = lvl[k][i];  // Already covers bits 0 to i.
      end else begin : g_join
        assign lvl[k+1][i] = kgp_combine(lvl[k][i], lvl[k][i-DIST]);
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result <= '0;
    end else begin
      for (int i = 0; i < WIDTH; i++) begin
        result.grp[i] <= lvl[LEVELS][i];
      end
      result.hsum <= hsum;
    end
  end

  // Bit 0 has no lower neighbour, so its group symbol is its own operand pair.
  a_sym0_is_pair: assert property (
    @(posedge clk) disable iff (!arst_n)
    $past(arst_n) |-> result.grp[0] == $past(kgp_encode(a[0], b[0]))
  ) else $error("Group symbol 0 does not match the captured operand pair.");

endmodule

//--- verilog/kgp_pkg.sv
// Kill/generate/propagate symbol types, operand and result types, symbol helper functions.
`include "adder_defs.svh"

package kgp_pkg;

  // Symbol codes. The code is the operand bit pair {a, b} read as a number.
  typedef enum logic [1:0] {
    kgp_kill    = 2'b00,
    kgp_prop_ba = 2'b01,
    kgp_prop_ab = 2'b10,
    kgp_gen     = 2'b11
  } kgp_e;

  typedef struct packed {
    logic a_bit;
    logic b_bit;
  } kgp_pair_t;

  // The encoder writes the pair view and the carry logic reads the code view.
  typedef union packed {
    kgp_pair_t pair;
    kgp_e      code;
  } kgp_sym_u;

  typedef logic [`ADD_WIDTH-1:0]  operand_t;
  typedef logic [`HALF_WIDTH-1:0] half_t;
  typedef logic [`ADD_WIDTH:0]    sum_t;  // Carry out in the top bit.

  // Symbol i covers bits 0 to i of the half.
  typedef struct packed {
    kgp_sym_u [`HALF_WIDTH-1:0] grp;
    half_t                      hsum;
  } half_result_t;

  function automatic kgp_sym_u kgp_encode(input logic a_bit, input logic b_bit);
    kgp_sym_u sym;
    sym.pair.a_bit = a_bit;
    sym.pair.b_bit = b_bit;
    return sym;
  endfunction

  // A kill or generate in the upper symbol decides; a propagate hands over to the lower one.
  function automatic kgp_sym_u kgp_combine(input kgp_sym_u upper, input kgp_sym_u lower);
    kgp_sym_u res;
    if (upper.code == kgp_kill || upper.code == kgp_gen) begin
      res = upper;
    end else begin
      res = lower;
    end
    return res;
  endfunction

  // Carry out of a group symbol for a known carry into the group.
  function automatic logic kgp_resolve(input kgp_sym_u grp, input logic carry_in);
    logic carry;
    case (grp.code)
      kgp_gen:  carry = 1'b1;
      kgp_kill: carry = 1'b0;
      default:  carry = carry_in;
    endcase
    return carry;
  endfunction

endpackage

//--- include/adder_defs.svh
// Operand width, half width, doubling level count and pipeline latency macros.
`ifndef ADDER_DEFS_SVH
`define ADDER_DEFS_SVH

// Full operand width of the adder.
`define ADD_WIDTH 64

// Width covered by one prefix tree.
`define HALF_WIDTH 32

// Doubling levels inside one tree, log2 of HALF_WIDTH.
`define HALF_LEVELS 5

// Clock edges from operand capture to a registered result.
`define PIPE_LATENCY 2

`endif
